// File: verilog/vdp_pkg.sv
// Shared constants, types and enums for the background video display processor
// Raster geometry, CPU address map and memory sizes

package vdp_pkg;

  typedef logic [8:0]  coord_t;    // Row or column count
  typedef logic [3:0]  color_t;    // Palette index
  typedef logic [23:0] rgb_t;      // {R, G, B}
  typedef logic [31:0] bgm_word_t; // Four BGM bytes

  ////////////////////
  // Raster geometry

  localparam coord_t num_cols = 9'd260;
  localparam coord_t num_rows = 9'd263;

  // Render window, 208 x 232
  localparam coord_t first_row_render = 9'd16;
  localparam coord_t last_row_render  = 9'd247;
  localparam coord_t first_col_render = 9'd23;
  localparam coord_t last_col_render  = 9'd230;

  localparam coord_t first_col_hsync = 9'd240;
  localparam coord_t last_col_hsync  = 9'd259;
  localparam coord_t first_row_vsync = 9'd257;
  localparam coord_t last_row_vsync  = 9'd259;

  ////////////////////
  // Memories and address map

  localparam int bgm_depth = 128;  // 32-bit words
  localparam int chr_depth = 1024; // Pattern bytes

  localparam logic [3:0] region_bgm_base = 4'b1000; // $1000-$11FF
  localparam logic [3:0] region_reg_base = 4'b1010; // $1400-$15FF

  typedef enum logic {PALETTE_RGB, PALETTE_RF} palette_e;

  // OTHER is VRAM, OAM and APU space
  typedef enum logic [1:0] {REGION_NONE, REGION_BGM, REGION_REG, REGION_OTHER} bus_region_e;

endpackage

// File: verilog/vdp_cfg_if.sv
// Configuration group from the MMIO registers to the background renderer

interface vdp_cfg_if;

  logic              bm_ena;    // Bitmap enable
  logic              bm_lores;  // Lo-res bitmap
  logic              bm_invx;   // Invert XMAX effect
  logic              bm_invy;   // Invert YMAX effect
  logic [3:0]        bm_xmax;
  logic [3:0]        bm_ymax;
  vdp_pkg::color_t   bm_clr_bg;
  vdp_pkg::color_t   bm_clr_fg; // Hi-res only
  vdp_pkg::color_t   ch_clr_bg;
  vdp_pkg::color_t   ch_clr_fg;

  modport regs (
    output bm_ena, bm_lores, bm_invx, bm_invy, bm_xmax, bm_ymax,
    output bm_clr_bg, bm_clr_fg, ch_clr_bg, ch_clr_fg
  );

  modport render (
    input bm_ena, bm_lores, bm_invx, bm_invy, bm_xmax, bm_ymax,
    input bm_clr_bg, bm_clr_fg, ch_clr_bg, ch_clr_fg
  );

endinterface

// File: verilog/host_bus.sv
// CPU slave bus, decodes BGM and MMIO space and holds the four control registers
// Read data is latched on the pixel clock enable

module host_bus (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                CE,
  input  logic [12:0]         A,
  input  logic [7:0]          DB_I,
  input  logic                CSB,
  input  logic                RDB,
  input  logic                WRB,
  input  vdp_pkg::bgm_word_t  bgm_rdata,
  output logic [7:0]          DB_O,
  output logic                DB_OE,
  output logic [3:0]          bgm_we,
  output logic [6:0]          bgm_addr,
  output logic [7:0]          bgm_wdata,
  vdp_cfg_if.regs             cfg
);

  vdp_pkg::bus_region_e region;
  logic                 cpu_rd, cpu_wr;
  logic [7:0]           ioreg [4];
  logic [7:0]           ioreg_do;

  always_comb begin
    if (CSB)
      region = vdp_pkg::REGION_NONE;
    else if (A[12:9] == vdp_pkg::region_bgm_base)
      region = vdp_pkg::REGION_BGM;
    else if (A[12:9] == vdp_pkg::region_reg_base)
      region = vdp_pkg::REGION_REG;
    else
      region = vdp_pkg::REGION_OTHER;
  end

  assign cpu_rd = ~CSB & ~RDB;
  assign cpu_wr = ~CSB & ~WRB;

  ////////////////////
  // MMIO registers

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++)
        ioreg[i] <= 8'h00;
    end else if (cpu_wr && region == vdp_pkg::REGION_REG) begin
      ioreg[A[1:0]] <= DB_I; // Held write just rewrites the same byte
    end
  end

  assign ioreg_do = ioreg[A[1:0]];

  // Sprite bits 2, 4, 5 of reg 0 are kept for read-back only
  assign cfg.bm_ena    = ioreg[0][0];
  assign cfg.bm_lores  = ioreg[0][1];
  assign cfg.bm_invx   = ioreg[0][6];
  assign cfg.bm_invy   = ioreg[0][7];
  assign cfg.bm_clr_bg = ioreg[1][3:0];
  assign cfg.bm_clr_fg = ioreg[1][7:4];
  assign cfg.bm_xmax   = ioreg[2][3:0];
  assign cfg.bm_ymax   = ioreg[2][7:4];
  assign cfg.ch_clr_bg = ioreg[3][3:0];
  assign cfg.ch_clr_fg = ioreg[3][7:4];

  ////////////////////
  // BGM port and read latch

  assign bgm_addr  = A[8:2];
  assign bgm_wdata = DB_I;
  assign bgm_we    = {3'b000, cpu_wr && region == vdp_pkg::REGION_BGM} << A[1:0]; // Lane

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n)
      DB_O <= 8'h00;
    else if (CE && cpu_rd) begin
      if (region == vdp_pkg::REGION_BGM)
        DB_O <= bgm_rdata[{A[1:0], 3'b000} +: 8];
      else if (region == vdp_pkg::REGION_REG)
        DB_O <= ioreg_do;
      // Other space keeps the last value
    end
  end

  assign DB_OE = cpu_rd;

endmodule

// File: verilog/raster_timing.sv
// Raster counters for a 260 x 263 frame
// Render window, sync and blanking flags

module raster_timing (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            CE,
  output vdp_pkg::coord_t row,
  output vdp_pkg::coord_t col,
  output logic            vis,
  output logic            DE,
  output logic            HS,
  output logic            VS,
  output logic            VBL
);

  logic render_row, render_col;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      row <= '0;
      col <= '0;
    end else if (CE) begin
      if (col == vdp_pkg::num_cols - 9'd1) begin
        col <= '0;
        if (row == vdp_pkg::num_rows - 9'd1)
          row <= '0;
        else
          row <= row + 9'd1;
      end else begin
        col <= col + 9'd1;
      end
    end
  end

  assign render_row = (row >= vdp_pkg::first_row_render) && (row <= vdp_pkg::last_row_render);
  assign render_col = (col >= vdp_pkg::first_col_render) && (col <= vdp_pkg::last_col_render);
  assign vis        = render_row & render_col;

  // Flags trail the counters by one CE
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      DE  <= 1'b0;
      HS  <= 1'b0;
      VS  <= 1'b0;
      VBL <= 1'b0;
    end else if (CE) begin
      DE  <= vis;
      HS  <= (col >= vdp_pkg::first_col_hsync) && (col <= vdp_pkg::last_col_hsync);
      VS  <= (row >= vdp_pkg::first_row_vsync) && (row <= vdp_pkg::last_row_vsync);
      VBL <= ~render_row;
    end
  end

endmodule

// File: verilog/tile_memory.sv
// Background memory and character pattern ROM
// BGM is dual-ported, CPU on one side and renderer on the other

module tile_memory (
  input  logic               CLK,
  input  logic [3:0]         bgm_we,
  input  logic [6:0]         bgm_addr,
  input  logic [7:0]         bgm_wdata,
  input  logic [6:0]         bg_addr,
  input  logic [9:0]         chr_addr,
  input  logic               ROMINIT_SEL_CHR,
  input  logic [9:0]         ROMINIT_ADDR,
  input  logic [7:0]         ROMINIT_DATA,
  input  logic               ROMINIT_VALID,
  output vdp_pkg::bgm_word_t bgm_rdata,
  output vdp_pkg::bgm_word_t bg_rdata,
  output logic [7:0]         chr_rdata
);

  vdp_pkg::bgm_word_t bgm_mem [vdp_pkg::bgm_depth];
  logic [7:0]         chr_mem [vdp_pkg::chr_depth];

  ////////////////////
  // BGM

  // CPU port, byte-lane writes
  always_ff @(posedge CLK) begin
    bgm_rdata <= bgm_mem[bgm_addr];
    for (int i = 0; i < 4; i++) begin
      if (bgm_we[i])
        bgm_mem[bgm_addr][i*8 +: 8] <= bgm_wdata;
    end
  end

  always_ff @(posedge CLK) begin
    bg_rdata <= bgm_mem[bg_addr]; // Render port
  end

  ////////////////////
  // CHR

  always_ff @(posedge CLK) begin
    if (ROMINIT_SEL_CHR && ROMINIT_VALID)
      chr_mem[ROMINIT_ADDR] <= ROMINIT_DATA;
    chr_rdata <= chr_mem[chr_addr];
  end

endmodule

// File: verilog/bg_render.sv
// Background renderer, character window and bitmap modes
// Loads one 8-pixel tile pattern per tile and shifts it out on CE

module bg_render (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               CE,
  input  vdp_pkg::coord_t    row,
  input  vdp_pkg::coord_t    col,
  input  vdp_pkg::bgm_word_t bg_rdata,
  input  logic [7:0]         chr_rdata,
  output logic [6:0]         bg_addr,
  output logic [9:0]         chr_addr,
  output vdp_pkg::color_t    bg_px,
  vdp_cfg_if.render          cfg
);

  logic [4:0]      tx, ty;
  logic            tce;          // Tile load point
  logic            xwin, ywin, ch_win, bm_win;
  logic [7:0]      bgm_byte;
  logic [7:0]      ch_pat, bm_pat, pat;
  logic [2:0]      hi_sel, lo_sel;
  logic [1:0]      hi_bits;
  logic [3:0]      lo_nib;
  vdp_pkg::color_t bm_bgc, bm_fgc;
  vdp_pkg::color_t px_bgc, px_fgc;
  logic [7:0]      shift_q;

  assign tx  = col[7:3];
  assign ty  = row[7:3];
  assign tce = (col[2:0] == 3'd4); // Memories have settled by here

  assign xwin   = (tx[4:1] < cfg.bm_xmax) ^ cfg.bm_invx;
  assign ywin   = (ty[4:1] < cfg.bm_ymax) ^ cfg.bm_invy;
  assign ch_win = xwin & ywin;
  assign bm_win = cfg.bm_ena & ~ch_win;

  // Tile fetch, one byte per tile
  assign bg_addr  = {ty[4:1], tx[4:2]};
  assign bgm_byte = bg_rdata[{tx[1:0], 3'b000} +: 8];
  assign chr_addr = {bgm_byte[6:0], row[2:0]};
  assign ch_pat   = ty[0] ? 8'h00 : {2'b00, chr_rdata[7:2]}; // Odd tile rows blank

  // Bitmap field select by row
  assign hi_sel  = {~row[3:2], 1'b0};
  assign lo_sel  = {~row[3], 2'b00};
  assign hi_bits = bgm_byte[hi_sel +: 2];
  assign lo_nib  = bgm_byte[lo_sel +: 4];

  always_comb begin
    bm_bgc = cfg.bm_clr_bg;
    bm_fgc = cfg.bm_clr_fg;
    bm_pat = 8'h00;
    if (bm_win) begin
      if (cfg.bm_lores) begin
        if (lo_nib != 4'd0) begin // Nibble 0 shows the background
          bm_pat = 8'hff;
          bm_fgc = lo_nib;
        end
      end else begin
        bm_pat = {{4{hi_bits[1]}}, {4{hi_bits[0]}}};
      end
    end
  end

  // Patterns go out LSB first, so flip them on load
  always_comb begin
    for (int i = 0; i < 8; i++)
      pat[7-i] = ch_win ? ch_pat[i] : bm_pat[i];
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= 8'h00;
      px_bgc  <= '0;
      px_fgc  <= '0;
    end else if (CE) begin
      if (tce) begin
        shift_q <= pat;
        px_bgc  <= ch_win ? cfg.ch_clr_bg : bm_bgc;
        px_fgc  <= ch_win ? cfg.ch_clr_fg : bm_fgc;
      end else begin
        shift_q <= {1'b0, shift_q[7:1]};
      end
    end
  end

  assign bg_px = shift_q[0] ? px_fgc : px_bgc;

endmodule

// File: verilog/color_gen.sv
// Colour generator, blanks outside the render window
// Two 16-entry palettes, RGB connector and RF modulator

module color_gen (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              CE,
  input  logic              vis,
  input  vdp_pkg::color_t   bg_px,
  input  vdp_pkg::palette_e CFG_PALETTE,
  output vdp_pkg::rgb_t     RGB
);

  logic            vis_d;
  vdp_pkg::color_t pd;

  // Same lag as DE
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n)
      vis_d <= 1'b0;
    else if (CE)
      vis_d <= vis;
  end

  assign pd = vis_d ? bg_px : 4'd1; // Black border

  always_comb begin
    RGB = '0;
    if (CFG_PALETTE == vdp_pkg::PALETTE_RGB) begin
      // Levels drop as R+G+B rises on the connector
      case (pd)
        4'd0:  RGB = {8'd0,   8'd0,   8'd160};
        4'd1:  RGB = {8'd0,   8'd0,   8'd0  };
        4'd2:  RGB = {8'd0,   8'd0,   8'd245};
        4'd3:  RGB = {8'd160, 8'd0,   8'd235};
        4'd4:  RGB = {8'd0,   8'd245, 8'd0  };
        4'd5:  RGB = {8'd150, 8'd235, 8'd150};
        4'd6:  RGB = {8'd0,   8'd235, 8'd235};
        4'd7:  RGB = {8'd0,   8'd160, 8'd0  };
        4'd8:  RGB = {8'd245, 8'd0,   8'd0  };
        4'd9:  RGB = {8'd235, 8'd160, 8'd0  };
        4'd10: RGB = {8'd235, 8'd0,   8'd235};
        4'd11: RGB = {8'd235, 8'd150, 8'd150};
        4'd12: RGB = {8'd235, 8'd235, 8'd0  };
        4'd13: RGB = {8'd160, 8'd160, 8'd0  };
        4'd14: RGB = {8'd150, 8'd150, 8'd150};
        default: RGB = {8'd225, 8'd225, 8'd225};
      endcase
    end else begin
      // RF output, noticeably shifted from RGB
      case (pd)
        4'd0:  RGB = {8'd0,   8'd90,  8'd156};
        4'd1:  RGB = {8'd0,   8'd0,   8'd0  };
        4'd2:  RGB = {8'd58,  8'd148, 8'd255};
        4'd3:  RGB = {8'd0,   8'd0,   8'd255};
        4'd4:  RGB = {8'd16,  8'd214, 8'd0  };
        4'd5:  RGB = {8'd66,  8'd255, 8'd16 };
        4'd6:  RGB = {8'd123, 8'd230, 8'd197};
        4'd7:  RGB = {8'd0,   8'd173, 8'd0  };
        4'd8:  RGB = {8'd255, 8'd41,  8'd148};
        4'd9:  RGB = {8'd255, 8'd49,  8'd16 };
        4'd10: RGB = {8'd255, 8'd58,  8'd255};
        4'd11: RGB = {8'd239, 8'd156, 8'd255};
        4'd12: RGB = {8'd255, 8'd206, 8'd33 };
        4'd13: RGB = {8'd74,  8'd123, 8'd16 };
        4'd14: RGB = {8'd165, 8'd148, 8'd165};
        default: RGB = {8'd255, 8'd255, 8'd255};
      endcase
    end
  end

endmodule

// File: verilog/epochtv1_bg.sv
// Background half of a home-console video display processor
// CPU bus, raster timing, tile memories, background renderer and colour output

module epochtv1_bg (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              CE,        // Pixel clock enable
  input  logic              ROMINIT_SEL_CHR,
  input  logic [9:0]        ROMINIT_ADDR,
  input  logic [7:0]        ROMINIT_DATA,
  input  logic              ROMINIT_VALID,
  input  vdp_pkg::palette_e CFG_PALETTE,
  input  logic [12:0]       A,
  input  logic [7:0]        DB_I,
  output logic [7:0]        DB_O,
  output logic              DB_OE,
  input  logic              RDB,
  input  logic              WRB,
  input  logic              CSB,
  output logic              VBL,
  output logic              DE,
  output logic              HS,
  output logic              VS,
  output vdp_pkg::rgb_t     RGB
);

  vdp_pkg::coord_t    row, col;
  logic               vis;
  logic [3:0]         bgm_we;
  logic [6:0]         bgm_addr, bg_addr;
  logic [7:0]         bgm_wdata, chr_rdata;
  logic [9:0]         chr_addr;
  vdp_pkg::bgm_word_t bgm_rdata, bg_rdata;
  vdp_pkg::color_t    bg_px;

  vdp_cfg_if cfg_if ();

  host_bus host_bus_inst (
    .CLK, .rst_n, .CE, .A, .DB_I, .CSB, .RDB, .WRB, .bgm_rdata,
    .DB_O, .DB_OE, .bgm_we, .bgm_addr, .bgm_wdata, .cfg(cfg_if.regs)
  );

  raster_timing raster_timing_inst (
    .CLK, .rst_n, .CE, .row, .col, .vis, .DE, .HS, .VS, .VBL
  );

  tile_memory tile_memory_inst (
    .CLK, .bgm_we, .bgm_addr, .bgm_wdata, .bg_addr, .chr_addr,
    .ROMINIT_SEL_CHR, .ROMINIT_ADDR, .ROMINIT_DATA, .ROMINIT_VALID,
    .bgm_rdata, .bg_rdata, .chr_rdata
  );

  bg_render bg_render_inst (
    .CLK, .rst_n, .CE, .row, .col, .bg_rdata, .chr_rdata,
    .bg_addr, .chr_addr, .bg_px, .cfg(cfg_if.render)
  );

  color_gen color_gen_inst (
    .CLK, .rst_n, .CE, .vis, .bg_px, .CFG_PALETTE, .RGB
  );

endmodule

// File: test/tb_clock.sv
// Testbench clock source
// Free-running clock with a period of 100 time units

module tb_clock (
  output logic CLK
);

  initial CLK = 1'b0;

  always #50 CLK = ~CLK; // Half period

endmodule

// File: test/epochtv1_bg_asserts.sv
// Protocol assertions for the background VDP top level
// Raster flag relations and the CPU data bus enable

module epochtv1_bg_asserts (
  input logic CLK,
  input logic rst_n,
  input logic DE,
  input logic VBL,
  input logic VS,
  input logic DB_OE,
  input logic CSB,
  input logic RDB
);

  int fail_count = 0; // Read by the testbench at the end

  // Active picture only in unblanked rows
  de_outside_vbl: assert property (@(posedge CLK) disable iff (!rst_n) !(DE && VBL))
    else begin
      fail_count++;
      $error("DE is high while VBL is high");
    end

  vs_inside_vbl: assert property (@(posedge CLK) disable iff (!rst_n) VS |-> VBL)
    else begin
      fail_count++;
      $error("VS is high outside vertical blanking");
    end

  // Bus driven only for a selected read
  oe_on_read: assert property (@(posedge CLK) disable iff (!rst_n) DB_OE |-> (!CSB && !RDB))
    else begin
      fail_count++;
      $error("DB_OE is high without CSB and RDB both low");
    end

endmodule

// File: test/tb_epochtv1_bg.sv
// Testbench for the background video display processor
// Runs an operation trace through the CPU bus and ROM load port, then checks the raster

module tb_epochtv1_bg;

  logic              CLK;
  logic              rst_n;
  logic              CE;
  logic              ROMINIT_SEL_CHR;
  logic [9:0]        ROMINIT_ADDR;
  logic [7:0]        ROMINIT_DATA;
  logic              ROMINIT_VALID;
  vdp_pkg::palette_e CFG_PALETTE;
  logic [12:0]       A;
  logic [7:0]        DB_I;
  logic [7:0]        DB_O;
  logic              DB_OE;
  logic              RDB;
  logic              WRB;
  logic              CSB;
  logic              VBL;
  logic              DE;
  logic              HS;
  logic              VS;
  vdp_pkg::rgb_t     RGB;

  int checks;
  int errors;
  int timeouts;
  int frame_clks;  // CE cycles per frame
  int vbl_clks;    // CE cycles per frame outside the render rows
  int fd;

  // Results of the last frame scan
  int            frm_total, frm_de, frm_hs, frm_vs, frm_vbl, frm_bad;
  vdp_pkg::rgb_t frm_bad_exp, frm_bad_rgb; // First wrong pixel

  tb_clock tb_clock_inst (.CLK);

  epochtv1_bg epochtv1_bg_inst (.*);

  bind epochtv1_bg epochtv1_bg_asserts asserts_inst (
    .CLK(CLK), .rst_n(rst_n), .DE(DE), .VBL(VBL), .VS(VS),
    .DB_OE(DB_OE), .CSB(CSB), .RDB(RDB)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  ////////////////////
  // CPU bus and ROM load

  task automatic write_bus(input logic [12:0] addr, input logic [7:0] data);
    @(posedge CLK);
    A    <= addr;
    DB_I <= data;
    CSB  <= 1'b0;
    WRB  <= 1'b0;
    repeat (2) @(posedge CLK);
    CSB  <= 1'b1;
    WRB  <= 1'b1;
  endtask

  // Held for 4 CE cycles, sampled in the last one
  task automatic read_bus(input logic [12:0] addr, input logic [7:0] expected);
    string name;
    name = $sformatf("read %h", addr);
    @(posedge CLK);
    A   <= addr;
    CSB <= 1'b0;
    RDB <= 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    check_value({name, " DB_OE"}, 32'd1, {31'd0, DB_OE});
    check_value(name, {24'd0, expected}, {24'd0, DB_O});
    @(posedge CLK);
    CSB <= 1'b1;
    RDB <= 1'b1;
    @(negedge CLK);
    check_value({name, " DB_OE after release"}, 32'd0, {31'd0, DB_OE});
  endtask

  task automatic fill_bgm(input logic [7:0] data);
    int i;
    for (i = 0; i < 4 * vdp_pkg::bgm_depth; i++)
      write_bus(13'h1000 + 13'(i), data);
  endtask

  task automatic fill_chr(input logic [7:0] data);
    int i;
    for (i = 0; i < vdp_pkg::chr_depth; i++) begin
      @(posedge CLK);
      ROMINIT_SEL_CHR <= 1'b1;
      ROMINIT_VALID   <= 1'b1;
      ROMINIT_ADDR    <= 10'(i);
      ROMINIT_DATA    <= data;
    end
    @(posedge CLK);
    ROMINIT_SEL_CHR <= 1'b0;
    ROMINIT_VALID   <= 1'b0;
  endtask

  ////////////////////
  // Raster scanning

  task automatic wait_vs_rise(output logic found);
    int   n;
    logic vs_prev;
    found   = 1'b0;
    vs_prev = 1'b1; // A frame already in VS is no edge
    for (n = 0; n < 2 * frame_clks && !found; n++) begin
      @(negedge CLK);
      found   = !vs_prev && VS;
      vs_prev = VS;
    end
    if (!found) begin
      timeouts++;
      $display("Timeout: no rising edge on VS within two frames");
    end
  endtask

  // One frame from a VS rise up to the next, RGB must be 0 outside DE
  task automatic scan_frame(input vdp_pkg::rgb_t expected_rgb);
    int            n;
    logic          done, vs_prev;
    vdp_pkg::rgb_t want;
    frm_total   = 0;
    frm_de      = 0;
    frm_hs      = 0;
    frm_vs      = 0;
    frm_vbl     = 0;
    frm_bad     = 0;
    frm_bad_exp = '0;
    frm_bad_rgb = '0;
    wait_vs_rise(done);
    if (!done)
      return;
    done = 1'b0;
    n    = 0;
    while (!done && n < 2 * frame_clks) begin
      frm_total++;
      if (DE) frm_de++;
      if (HS) frm_hs++;
      if (VS) frm_vs++;
      if (VBL) frm_vbl++;
      want = DE ? expected_rgb : 24'h000000;
      if (RGB !== want) begin
        if (frm_bad == 0) begin
          frm_bad_exp = want;
          frm_bad_rgb = RGB;
        end
        frm_bad++;
      end
      vs_prev = VS;
      @(negedge CLK);
      n++;
      done = !vs_prev && VS;
    end
    if (!done) begin
      timeouts++;
      $display("Timeout: VS did not rise again within two frames");
    end
  endtask

  ////////////////////
  // Trace handling

  task automatic skip_line(input int file);
    int c;
    c = $fgetc(file);
    while (c != 10 && c != -1)
      c = $fgetc(file);
  endtask

  task automatic run_op(input logic [15:0] op, input logic [31:0] addr,
                        input logic [31:0] data, input logic [31:0] expected);
    case (op)
      "wr": write_bus(addr[12:0], data[7:0]);
      "rd": read_bus(addr[12:0], expected[7:0]);
      "bf": fill_bgm(data[7:0]);
      "cf": fill_chr(data[7:0]);
      "pl": begin
        @(posedge CLK);
        CFG_PALETTE <= vdp_pkg::palette_e'(data[0]);
      end
      "fr": begin
        scan_frame(expected[23:0]);
        if (timeouts == 0)
          check_value($sformatf("frame RGB, %0d wrong pixels", frm_bad),
                      {8'd0, frm_bad_exp}, {8'd0, frm_bad_rgb});
      end
      "fc": begin
        scan_frame(24'h000000);
        if (timeouts == 0) begin
          check_value("frame CE cycles", frame_clks, frm_total);
          check_value("frame DE cycles", addr, frm_de);
          check_value("frame HS cycles", data, frm_hs);
          check_value("frame VS cycles", expected, frm_vs);
          check_value("frame VBL cycles", vbl_clks, frm_vbl);
        end
      end
      default: begin
        errors++;
        $display("Unknown operation %s in the trace file", op);
      end
    endcase
  endtask

  initial begin
    logic [15:0] op;
    logic [31:0] f_addr, f_data, f_exp;
    int          n;
    rst_n           <= 1'b0;
    CE              <= 1'b1; // Every clock is a pixel
    ROMINIT_SEL_CHR <= 1'b0;
    ROMINIT_ADDR    <= '0;
    ROMINIT_DATA    <= '0;
    ROMINIT_VALID   <= 1'b0;
    CFG_PALETTE     <= vdp_pkg::PALETTE_RGB;
    A               <= '0;
    DB_I            <= '0;
    RDB             <= 1'b1;
    WRB             <= 1'b1;
    CSB             <= 1'b1;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    frame_clks = int'(vdp_pkg::num_rows) * int'(vdp_pkg::num_cols);
    // Blanked rows are all rows outside the render window
    vbl_clks   = (int'(vdp_pkg::num_rows) - int'(vdp_pkg::last_row_render)
                  + int'(vdp_pkg::first_row_render) - 1) * int'(vdp_pkg::num_cols);

    repeat (5) @(posedge CLK);
    rst_n <= 1'b1;

    fd = $fopen("test/bg_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the trace file test/bg_trace.txt");
    end else begin
      n = $fscanf(fd, "%s", op);
      while (n == 1 && timeouts == 0) begin
        if (op == "//") begin
          skip_line(fd);
        end else begin
          n = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
          if (n == 3)
            run_op(op, f_addr, f_data, f_exp);
          else begin
            errors++;
            $display("Trace line for operation %s has missing fields", op);
          end
        end
        n = $fscanf(fd, "%s", op);
      end
      $fclose(fd);
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, epochtv1_bg_inst.asserts_inst.fail_count);
    if (errors == 0 && timeouts == 0 && epochtv1_bg_inst.asserts_inst.fail_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: test/bg_trace.txt
// op  addr  data  expected  (hex; wr/rd bus write and read, bf/cf BGM and CHR fill)
// pl palette select, fr frame RGB scan, fc frame counts (addr DE, data HS, expected VS)
wr  1400  d7  00
wr  1401  5a  00
wr  1402  c3  00
wr  1403  81  00
rd  1400  00  d7
rd  1401  00  5a
rd  1402  00  c3
rd  1403  00  81
bf  0000  00  00
wr  1040  a5  00
wr  1041  3c  00
wr  1042  e7  00
wr  1043  18  00
rd  1040  00  a5
rd  1041  00  3c
rd  1042  00  e7
rd  1043  00  18
wr  11fe  96  00
rd  11fd  00  00
rd  11fe  00  96
rd  11ff  00  00
rd  1044  00  00
fc  bc80  148c  030c
cf  0000  00  00
wr  1400  00  00
wr  1401  03  00
wr  1402  ff  00
wr  1403  93  00
fr  0000  00  a000eb
pl  0000  01  00
fr  0000  00  0000ff
pl  0000  00  00
wr  1402  00  00
wr  1400  03  00
wr  1401  0a  00
bf  0000  55  00
fr  0000  00  96eb96
bf  0000  00  00
fr  0000  00  eb00eb

// File: list.f
verilog/vdp_pkg.sv
verilog/vdp_cfg_if.sv
verilog/host_bus.sv
verilog/raster_timing.sv
verilog/tile_memory.sv
verilog/bg_render.sv
verilog/color_gen.sv
verilog/epochtv1_bg.sv
test/tb_clock.sv
test/epochtv1_bg_asserts.sv
test/tb_epochtv1_bg.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_epochtv1_bg
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
